//--- verilog.f
source/decode_pkg.sv
source/decode_slot_if.sv
source/fetch_latch.sv
source/field_decoder.sv
source/op_decoder.sv
source/decode_issue.sv
source/decode_unit.sv
testbench/decode_unit_assertions.sv
testbench/decode_unit_tb.sv

//--- Bender.yml
package:
  name: decode_unit

sources:
  - source/decode_pkg.sv
  - source/decode_slot_if.sv
  - source/fetch_latch.sv
  - source/field_decoder.sv
  - source/op_decoder.sv
  - source/decode_issue.sv
  - source/decode_unit.sv
  - target: test
    files:
      - testbench/decode_unit_assertions.sv
      - testbench/decode_unit_tb.sv

//--- testbench/decode_unit_tb.sv
// testbench for decode_unit, random fetch traffic checked against a reference decoder each cycle
`timescale 1ns/10ps
`default_nettype none

module decode_unit_tb import decode_pkg::*; ();

  typedef enum {
    KIND_LEGAL,
    KIND_ILLEGAL,
    KIND_FETCH_ERROR,
    KIND_BRANCH_JUMP,
    KIND_BACKPRESSURE,
    KIND_FLUSH
  } kind_e;

  typedef struct packed {
    logic               error;
    logic [1:0]         ecause;
    logic [5:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [XLEN-1:0]    imm;
    logic [RSOP_W-1:0]  rsop;
    logic [RETOP_W-1:0] retop;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               uses_imm;
    logic               uses_memory;
    logic               uses_pc;
    logic               csr;
    logic [XLEN-1:2]    target;
  } expect_t;

  logic               clk;
  logic               arst_n_i;
  logic               fetch_valid_i;
  logic               fetch_error_i;
  logic [XLEN-1:1]    fetch_addr_i;
  logic [XLEN-1:0]    fetch_insn_i;
  logic [BPTAG_W-1:0] fetch_bptag_i;
  logic               fetch_bptaken_i;
  logic               rob_flush_i;
  logic               rob_full_i;
  logic [ROBID_W-1:0] rob_robid_i;
  logic               rename_stall_i;
  logic               decode_stall_o;
  logic [XLEN-1:2]    decode_addr_o;
  logic [XLEN-1:2]    decode_target_o;
  logic [5:0]         decode_rd_o;
  logic               rob_valid_o;
  logic               decode_error_o;
  ecause_e            decode_ecause_o;
  logic [RETOP_W-1:0] decode_retop_o;
  logic [BPTAG_W-1:0] decode_bptag_o;
  logic               decode_bptaken_o;
  logic               rename_valid_o;
  logic [RSOP_W-1:0]  decode_rsop_o;
  logic [ROBID_W-1:0] decode_robid_o;
  logic               uses_rs1_o;
  logic               uses_rs2_o;
  logic               uses_imm_o;
  logic               uses_memory_o;
  logic               uses_pc_o;
  logic               csr_access_o;
  logic [4:0]         decode_rs1_o;
  logic [4:0]         decode_rs2_o;
  logic [XLEN-1:0]    decode_imm_o;

  // expected slot contents
  logic               exp_valid;
  logic               exp_error;
  logic [XLEN-1:1]    exp_addr;
  logic [XLEN-1:0]    exp_insn;
  logic [BPTAG_W-1:0] exp_bptag;
  logic               exp_bptaken;
  logic               hold_fetch;

  string cur_test;
  int    cycles_per_test = 400;
  int    num_tests = 7;
  int    error_count = 0;
  int    check_count = 0;
  int    test_count = 0;
  int    test_errors = 0;
  int    issued = 0;

  logic [6:0] legal_ops [11] = '{7'h03, 7'h0f, 7'h13, 7'h17, 7'h23, 7'h33,
                                 7'h37, 7'h63, 7'h67, 7'h6f, 7'h73};
  logic [6:0] branch_ops [3] = '{7'h63, 7'h67, 7'h6f};

  decode_unit u_decode_unit (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic one_in(int n);
    return ($urandom % n) == 0;
  endfunction

  function automatic logic known_opcode(logic [4:0] op5);
    case (op5)
      5'h00, 5'h03, 5'h04, 5'h05, 5'h08, 5'h0c,
      5'h0d, 5'h18, 5'h19, 5'h1b, 5'h1c: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] make_insn(kind_e kind);
    logic [XLEN-1:0] w;
    logic [4:0]      op5;
    w = $urandom;
    case (kind)
      KIND_ILLEGAL: begin
        if (one_in(2)) begin
          w[1:0] = 2'($urandom % 3);
        end else begin
          op5 = 5'($urandom);
          while (known_opcode(op5)) op5 = 5'($urandom);
          w[6:0] = {op5, 2'b11};
        end
      end
      KIND_BRANCH_JUMP: w[6:0] = branch_ops[$urandom % 3];
      // some raw words slip through as illegal traffic
      default: if (!one_in(8)) w[6:0] = legal_ops[$urandom % 11];
    endcase
    return w;
  endfunction

  function automatic expect_t reference_decode(logic [XLEN-1:0] insn, logic err,
                                               logic [XLEN-1:1] addr);
    expect_t         e;
    logic [4:0]      op5;
    logic [2:0]      f3;
    logic            r, i, s, b, u, j, inv;
    logic            ld, jalr, auipc, uses_rd;
    logic [XLEN-1:0] sum;
    op5 = insn[6:2];
    f3  = insn[14:12];
    {r, i, s, b, u, j} = '0;
    inv = (insn[1:0] != 2'b11) || !known_opcode(op5);
    if (!inv) begin
      case (op5)
        5'h0c: r = 1'b1;
        5'h08: s = 1'b1;
        5'h18: b = 1'b1;
        5'h0d, 5'h05: u = 1'b1;
        5'h1b: j = 1'b1;
        default: i = 1'b1;
      endcase
    end
    e.imm = '0;
    if (i) e.imm = 32'($signed(insn[31:20]));
    if (s) e.imm = 32'($signed({insn[31:25], insn[11:7]}));
    if (b) e.imm = 32'($signed({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}));
    if (u) e.imm = {insn[31:12], 12'h000};
    if (j) e.imm = 32'($signed({insn[31], insn[19:12], insn[20], insn[30:21], 1'b0}));
    ld    = (op5 == 5'h00);
    jalr  = (op5 == 5'h19);
    auipc = (op5 == 5'h05);
    e.csr = (op5 == 5'h1c) && (f3[1:0] != 2'b00);
    uses_rd = (r | i | u | j) && (insn[11:7] != 5'd0);
    e.rd  = {!uses_rd, insn[11:7]};
    e.rs1 = insn[19:15];
    e.rs2 = insn[24:20];
    // immediate csr forms read no register
    e.uses_rs1    = r | s | b | (i & !(e.csr && f3[2]));
    e.uses_rs2    = r | s | b;
    e.uses_imm    = !r && !b;
    e.uses_memory = ld | s;
    e.uses_pc     = j | jalr | auipc;
    if (ld || s) e.rsop = {1'b0, s, f3};
    else if (r && insn[25]) e.rsop = {2'b11, f3};
    else if (jalr) e.rsop = 5'b10000;
    else if (b) e.rsop = {2'b01, !(f3[2] | f3[1]), f3[2:1]};
    else e.rsop = {1'b0, r & insn[30], f3};
    e.retop  = {b, f3[0], jalr, s, f3};
    e.error  = err | inv;
    e.ecause = !err ? ECAUSE_ILLEGAL : (addr[1] ? ECAUSE_IALIGN : ECAUSE_IFAULT);
    sum = {addr[XLEN-1:2], 2'b00} + e.imm;
    e.target = sum[XLEN-1:2];
    return e;
  endfunction

  task automatic compare_value(string what, logic [63:0] expected, logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("Error: test %s, %s expected %h actual %h", cur_test, what, expected, actual);
    end
  endtask

  task automatic check_outputs();
    expect_t e;
    compare_value("decode_stall", rob_full_i | rename_stall_i, decode_stall_o);
    compare_value("robid", rob_robid_i, decode_robid_o);
    compare_value("rob_valid", exp_valid, rob_valid_o);
    if (!exp_valid) begin
      compare_value("rename_valid", 1'b0, rename_valid_o);
    end else begin
      issued++;
      e = reference_decode(exp_insn, exp_error, exp_addr);
      compare_value("rename_valid", !e.error, rename_valid_o);
      compare_value("error", e.error, decode_error_o);
      compare_value("ecause", e.ecause, decode_ecause_o);
      compare_value("rd", e.rd, decode_rd_o);
      compare_value("rs1", e.rs1, decode_rs1_o);
      compare_value("rs2", e.rs2, decode_rs2_o);
      compare_value("imm", e.imm, decode_imm_o);
      compare_value("rsop", e.rsop, decode_rsop_o);
      compare_value("retop", e.retop, decode_retop_o);
      compare_value("uses_rs1", e.uses_rs1, uses_rs1_o);
      compare_value("uses_rs2", e.uses_rs2, uses_rs2_o);
      compare_value("uses_imm", e.uses_imm, uses_imm_o);
      compare_value("uses_memory", e.uses_memory, uses_memory_o);
      compare_value("uses_pc", e.uses_pc, uses_pc_o);
      compare_value("csr_access", e.csr, csr_access_o);
      compare_value("target", e.target, decode_target_o);
      compare_value("addr", exp_addr[XLEN-1:2], decode_addr_o);
      compare_value("bptag", exp_bptag, decode_bptag_o);
      compare_value("bptaken", exp_bptaken, decode_bptaken_o);
    end
  endtask

  task automatic drive_inputs(kind_e kind);
    rob_full_i     = one_in(kind == KIND_BACKPRESSURE ? 3 : 12);
    rename_stall_i = one_in(kind == KIND_BACKPRESSURE ? 3 : 12);
    rob_flush_i    = one_in(kind == KIND_FLUSH ? 4 : 32);
    rob_robid_i    = ROBID_W'($urandom);
    // fetch keeps its word while decode stalls
    if (!hold_fetch) begin
      fetch_valid_i   = !one_in(4);
      fetch_error_i   = one_in(kind == KIND_FETCH_ERROR ? 2 : 16);
      fetch_addr_i    = (XLEN-1)'($urandom);
      fetch_insn_i    = make_insn(kind);
      fetch_bptag_i   = BPTAG_W'($urandom);
      fetch_bptaken_i = one_in(2);
    end
    hold_fetch = rob_full_i | rename_stall_i;
  endtask

  // what the next rising edge does to the slot
  task automatic update_model();
    if (rob_flush_i) begin
      exp_valid = 1'b0;
    end else if (!hold_fetch) begin
      exp_valid = fetch_valid_i;
    end
    if (!hold_fetch && fetch_valid_i) begin
      exp_error   = fetch_error_i;
      exp_addr    = fetch_addr_i;
      exp_insn    = fetch_insn_i;
      exp_bptag   = fetch_bptag_i;
      exp_bptaken = fetch_bptaken_i;
    end
  endtask

  task automatic run_test(string name, kind_e kind);
    cur_test    = name;
    test_errors = 0;
    issued      = 0;
    repeat (cycles_per_test) begin
      @(negedge clk);
      check_outputs();
      drive_inputs(kind);
      update_model();
    end
    test_count++;
    $display("test %s finished: %0d cycles, %0d issued, %0d errors",
             name, cycles_per_test, issued, test_errors);
  endtask

  initial begin
    int unsigned limit;
    limit = num_tests * cycles_per_test * 4;
    repeat (limit) @(posedge clk);
    $display("watchdog: run timed out after %0d cycles", limit);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(35146));
    arst_n_i        = 1'b0;
    fetch_valid_i   = 1'b0;
    fetch_error_i   = 1'b0;
    fetch_addr_i    = '0;
    fetch_insn_i    = '0;
    fetch_bptag_i   = '0;
    fetch_bptaken_i = 1'b0;
    rob_flush_i     = 1'b0;
    rob_full_i      = 1'b0;
    rob_robid_i     = '0;
    rename_stall_i  = 1'b0;
    exp_valid       = 1'b0;
    hold_fetch      = 1'b0;

    cur_test    = "reset";
    test_errors = 0;
    repeat (16) begin
      @(negedge clk);
      check_outputs();
    end
    arst_n_i = 1'b1;
    test_count++;
    $display("test reset finished: 16 cycles, %0d errors", test_errors);

    run_test("legal", KIND_LEGAL);
    run_test("illegal", KIND_ILLEGAL);
    run_test("fetch_error", KIND_FETCH_ERROR);
    run_test("branch_jump", KIND_BRANCH_JUMP);
    run_test("backpressure", KIND_BACKPRESSURE);
    run_test("flush", KIND_FLUSH);

    @(negedge clk);
    check_outputs();
    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/decode_unit_assertions.sv
// concurrent checks on the decode stall, issue handshake and flush, bound into decode_unit
`timescale 1ns/10ps
`default_nettype none

module decode_unit_assertions import decode_pkg::*; (
  input logic               clk,
  input logic               arst_n_i,
  input logic               rob_full_i,
  input logic               rename_stall_i,
  input logic               rob_flush_i,
  input logic               stall_i,
  input logic               rob_valid_i,
  input logic               rename_valid_i,
  input logic               error_i,
  input logic [1:0]         ecause_i,
  input logic [5:0]         rd_i,
  input logic [XLEN-1:0]    imm_i,
  input logic [RSOP_W-1:0]  rsop_i,
  input logic [RETOP_W-1:0] retop_i,
  input logic [XLEN-1:2]    target_i
);

  stall_is_or: assert property (@(posedge clk) disable iff (!arst_n_i)
    stall_i == (rob_full_i | rename_stall_i))
    else $error("decode stall is not rob full or rename stall");

  rename_needs_rob: assert property (@(posedge clk) disable iff (!arst_n_i)
    rename_valid_i |-> rob_valid_i && !error_i)
    else $error("rename valid without a clean rob entry");

  flush_drops_slot: assert property (@(posedge clk) disable iff (!arst_n_i)
    rob_flush_i |=> !rob_valid_i)
    else $error("slot still valid after flush");

  // issued entry frozen while stalled
  hold_under_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
    stall_i && !rob_flush_i && rob_valid_i |=>
      $stable({rob_valid_i, rename_valid_i, error_i, ecause_i, rd_i, imm_i,
               rsop_i, retop_i, target_i}))
    else $error("issued instruction changed under stall");

endmodule

bind decode_unit decode_unit_assertions u_decode_unit_assertions (
  .clk            (clk),
  .arst_n_i       (arst_n_i),
  .rob_full_i     (rob_full_i),
  .rename_stall_i (rename_stall_i),
  .rob_flush_i    (rob_flush_i),
  .stall_i        (decode_stall_o),
  .rob_valid_i    (rob_valid_o),
  .rename_valid_i (rename_valid_o),
  .error_i        (decode_error_o),
  .ecause_i       (decode_ecause_o),
  .rd_i           (decode_rd_o),
  .imm_i          (decode_imm_o),
  .rsop_i         (decode_rsop_o),
  .retop_i        (decode_retop_o),
  .target_i       (decode_target_o)
);

`default_nettype wire

//--- source/decode_unit.sv
// top of the RV32I decode stage, fetch in and rob plus rename out on plain ports
`timescale 1ns/10ps
`default_nettype none

module decode_unit import decode_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,

  // fetch
  input  logic                 fetch_valid_i,
  input  logic                 fetch_error_i,
  input  logic [XLEN-1:1]      fetch_addr_i,
  input  logic [XLEN-1:0]      fetch_insn_i,
  input  logic [BPTAG_W-1:0]   fetch_bptag_i,
  input  logic                 fetch_bptaken_i,
  output logic                 decode_stall_o,

  output logic [XLEN-1:2]      decode_addr_o,
  output logic [5:0]           decode_rd_o,

  // rob
  output logic                 rob_valid_o,
  output logic                 decode_error_o,
  output ecause_e              decode_ecause_o,
  output logic [RETOP_W-1:0]   decode_retop_o,
  output logic [BPTAG_W-1:0]   decode_bptag_o,
  output logic                 decode_bptaken_o,
  output logic [XLEN-1:2]      decode_target_o,
  input  logic                 rob_flush_i,
  input  logic                 rob_full_i,
  input  logic [ROBID_W-1:0]   rob_robid_i,

  // rename
  output logic                 rename_valid_o,
  output logic [RSOP_W-1:0]    decode_rsop_o,
  output logic [ROBID_W-1:0]   decode_robid_o,
  output logic                 uses_rs1_o,
  output logic                 uses_rs2_o,
  output logic                 uses_imm_o,
  output logic                 uses_memory_o,
  output logic                 uses_pc_o,
  output logic                 csr_access_o,
  output logic [4:0]           decode_rs1_o,
  output logic [4:0]           decode_rs2_o,
  output logic [XLEN-1:0]      decode_imm_o,
  input  logic                 rename_stall_i
);

  logic       stall;
  field_res_t field_res;
  op_res_t    op_res;

  decode_slot_if slot_if ();

  assign decode_stall_o = stall;

  fetch_latch u_fetch_latch (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .flush_i         (rob_flush_i),
    .stall_i         (stall),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_error_i   (fetch_error_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_insn_i    (fetch_insn_i),
    .fetch_bptag_i   (fetch_bptag_i),
    .fetch_bptaken_i (fetch_bptaken_i),
    .slot            (slot_if.latch)
  );

  field_decoder u_field_decoder (
    .slot    (slot_if.sink),
    .field_o (field_res)
  );

  op_decoder u_op_decoder (
    .slot    (slot_if.sink),
    .field_i (field_res),
    .op_o    (op_res)
  );

  decode_issue u_decode_issue (
    .slot             (slot_if.sink),
    .field_i          (field_res),
    .op_i             (op_res),
    .rob_full_i       (rob_full_i),
    .rename_stall_i   (rename_stall_i),
    .rob_robid_i      (rob_robid_i),
    .stall_o          (stall),
    .decode_addr_o    (decode_addr_o),
    .decode_rd_o      (decode_rd_o),
    .rob_valid_o      (rob_valid_o),
    .decode_error_o   (decode_error_o),
    .decode_ecause_o  (decode_ecause_o),
    .decode_retop_o   (decode_retop_o),
    .decode_bptag_o   (decode_bptag_o),
    .decode_bptaken_o (decode_bptaken_o),
    .decode_target_o  (decode_target_o),
    .rename_valid_o   (rename_valid_o),
    .decode_rsop_o    (decode_rsop_o),
    .decode_robid_o   (decode_robid_o),
    .uses_rs1_o       (uses_rs1_o),
    .uses_rs2_o       (uses_rs2_o),
    .uses_imm_o       (uses_imm_o),
    .uses_memory_o    (uses_memory_o),
    .uses_pc_o        (uses_pc_o),
    .csr_access_o     (csr_access_o),
    .decode_rs1_o     (decode_rs1_o),
    .decode_rs2_o     (decode_rs2_o),
    .decode_imm_o     (decode_imm_o)
  );

endmodule

`default_nettype wire

//--- source/decode_issue.sv
// merges slot state and decoder results into the rob and rename channels and the fetch stall
`timescale 1ns/10ps
`default_nettype none

module decode_issue import decode_pkg::*; (
  decode_slot_if.sink          slot,
  input  field_res_t           field_i,
  input  op_res_t              op_i,

  input  logic                 rob_full_i,
  input  logic                 rename_stall_i,
  input  logic [ROBID_W-1:0]   rob_robid_i,
  output logic                 stall_o,

  // shared by rob and rename
  output logic [XLEN-1:2]      decode_addr_o,
  output logic [5:0]           decode_rd_o,

  // rob channel
  output logic                 rob_valid_o,
  output logic                 decode_error_o,
  output ecause_e              decode_ecause_o,
  output logic [RETOP_W-1:0]   decode_retop_o,
  output logic [BPTAG_W-1:0]   decode_bptag_o,
  output logic                 decode_bptaken_o,
  output logic [XLEN-1:2]      decode_target_o,

  // rename channel
  output logic                 rename_valid_o,
  output logic [RSOP_W-1:0]    decode_rsop_o,
  output logic [ROBID_W-1:0]   decode_robid_o,
  output logic                 uses_rs1_o,
  output logic                 uses_rs2_o,
  output logic                 uses_imm_o,
  output logic                 uses_memory_o,
  output logic                 uses_pc_o,
  output logic                 csr_access_o,
  output logic [4:0]           decode_rs1_o,
  output logic [4:0]           decode_rs2_o,
  output logic [XLEN-1:0]      decode_imm_o
);

  assign stall_o = rob_full_i | rename_stall_i;

  assign decode_addr_o = slot.addr[XLEN-1:2];
  // bit 5 marks a dead destination
  assign decode_rd_o   = {~field_i.uses_rd, field_i.rd};

  assign rob_valid_o    = slot.valid;
  assign decode_error_o = slot.error | (field_i.fmt == FMT_INVALID);

  always_comb begin
    if (slot.error) begin
      decode_ecause_o = slot.addr[1] ? ECAUSE_IALIGN : ECAUSE_IFAULT;
    end else begin
      decode_ecause_o = ECAUSE_ILLEGAL;
    end
  end

  assign decode_retop_o   = op_i.retop;
  assign decode_bptag_o   = slot.bptag;
  assign decode_bptaken_o = slot.bptaken;

  // aligned pc plus imm, imm bits 1:0 cannot carry into bit 2
  assign decode_target_o = slot.addr[XLEN-1:2] + field_i.imm[XLEN-1:2];

  assign rename_valid_o = slot.valid & ~decode_error_o;
  assign decode_rsop_o  = op_i.rsop;
  assign decode_robid_o = rob_robid_i;
  assign uses_rs1_o     = field_i.uses_rs1;
  assign uses_rs2_o     = field_i.uses_rs2;
  assign uses_imm_o     = field_i.uses_imm;
  assign uses_memory_o  = op_i.is_load | (field_i.fmt == FMT_S);
  assign uses_pc_o      = (field_i.fmt == FMT_J) | op_i.is_jalr | op_i.is_auipc;
  assign csr_access_o   = op_i.is_csr;
  assign decode_rs1_o   = field_i.rs1;
  assign decode_rs2_o   = field_i.rs2;
  assign decode_imm_o   = field_i.imm;

endmodule

`default_nettype wire

//--- source/op_decoder.sv
// derives opcode class flags, reservation-station op and retire op of the latched instruction
`timescale 1ns/10ps
`default_nettype none

module op_decoder import decode_pkg::*; (
  decode_slot_if.sink      slot,
  input  field_res_t       field_i,
  output op_res_t          op_o
);

  opcode_e            opcode;
  logic [2:0]         funct3;
  logic [2:0]         brop;
  logic               is_r;
  logic               is_s;
  logic               is_b;
  logic               is_load;
  logic               is_jalr;
  logic               is_auipc;
  logic               is_csr;
  logic               is_complex;
  logic [RSOP_W-1:0]  rsop;
  logic [RETOP_W-1:0] retop;

  assign opcode = opcode_e'(slot.insn[6:2]);
  assign funct3 = slot.insn[14:12];

  // format comes from the field decoder
  assign is_r = (field_i.fmt == FMT_R);
  assign is_s = (field_i.fmt == FMT_S);
  assign is_b = (field_i.fmt == FMT_B);

  assign is_load  = (opcode == OPC_LOAD);
  assign is_jalr  = (opcode == OPC_JALR);
  assign is_auipc = (opcode == OPC_AUIPC);
  assign is_csr   = (opcode == OPC_SYSTEM) & (funct3[1:0] != 2'b00);

  // mul/div group of OP
  assign is_complex = is_r & slot.insn[25];

  // eq/ne map to 1xx, signed and unsigned compares keep funct3[2:1]
  assign brop = {~|funct3[2:1], funct3[2:1]};

  always_comb begin
    if (is_load | is_s) begin
      rsop = {1'b0, is_s, funct3};
    end else if (is_complex) begin
      rsop = {2'b11, funct3};
    end else if (is_jalr) begin
      rsop = 5'b10000;
    end else if (is_b) begin
      rsop = {2'b01, brop};
    end else begin
      rsop = {1'b0, is_r & slot.insn[30], funct3};
    end
  end

  assign retop = {is_b, funct3[0], is_jalr, is_s, funct3};

  assign op_o = '{
    rsop:     rsop,
    retop:    retop,
    is_load:  is_load,
    is_jalr:  is_jalr,
    is_auipc: is_auipc,
    is_csr:   is_csr
  };

endmodule

`default_nettype wire

//--- source/field_decoder.sv
// decodes format, immediate, register fields and operand usage of the latched instruction
`timescale 1ns/10ps
`default_nettype none

module field_decoder import decode_pkg::*; (
  decode_slot_if.sink      slot,
  output field_res_t       field_o
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] insn;
  fmt_e            fmt;
  logic [XLEN-1:0] imm;
  logic            csr_imm;
  logic            is_r;
  logic            is_i;
  logic            is_s;
  logic            is_b;
  logic            is_u;
  logic            is_j;

  assign insn   = slot.insn;
  assign opcode = opcode_e'(insn[6:2]);
  assign funct3 = insn[14:12];

  // everything not listed is unimplemented
  always_comb begin
    fmt = FMT_INVALID;
    if (insn[1:0] == 2'b11) begin
      case (opcode)
        OPC_OP:       fmt = FMT_R;
        OPC_OP_IMM,
        OPC_LOAD,
        OPC_JALR,
        OPC_MISC_MEM,
        OPC_SYSTEM:   fmt = FMT_I;
        OPC_STORE:    fmt = FMT_S;
        OPC_BRANCH:   fmt = FMT_B;
        OPC_LUI,
        OPC_AUIPC:    fmt = FMT_U;
        OPC_JAL:      fmt = FMT_J;
        default:      fmt = FMT_INVALID;
      endcase
    end
  end

  assign is_r = (fmt == FMT_R);
  assign is_i = (fmt == FMT_I);
  assign is_s = (fmt == FMT_S);
  assign is_b = (fmt == FMT_B);
  assign is_u = (fmt == FMT_U);
  assign is_j = (fmt == FMT_J);

  always_comb begin
    case (fmt)
      FMT_I:   imm = {{(XLEN-12){insn[31]}}, insn[31:20]};
      FMT_S:   imm = {{(XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
      FMT_B:   imm = {{(XLEN-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      FMT_U:   imm = {insn[31:12], 12'b0};
      FMT_J:   imm = {{(XLEN-20){insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // csrrwi, csrrsi, csrrci carry a uimm in the rs1 field
  assign csr_imm = (opcode == OPC_SYSTEM) & funct3[2] & (funct3[1:0] != 2'b00);

  assign field_o = '{
    fmt:      fmt,
    imm:      imm,
    rs1:      insn[19:15],
    rs2:      insn[24:20],
    rd:       insn[11:7],
    uses_rd:  (is_r | is_i | is_u | is_j) & (insn[11:7] != 5'd0),
    uses_rs1: is_r | is_s | is_b | (is_i & ~csr_imm),
    uses_rs2: is_r | is_s | is_b,
    uses_imm: ~is_r & ~is_b
  };

endmodule

`default_nettype wire

//--- source/fetch_latch.sv
// decode pipeline register, holds the fetched slot under stall and drops it on flush
`timescale 1ns/10ps
`default_nettype none

module fetch_latch import decode_pkg::*; (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               flush_i,
  input  logic               stall_i,

  input  logic               fetch_valid_i,
  input  logic               fetch_error_i,
  input  logic [XLEN-1:1]    fetch_addr_i,
  input  logic [XLEN-1:0]    fetch_insn_i,
  input  logic [BPTAG_W-1:0] fetch_bptag_i,
  input  logic               fetch_bptaken_i,

  decode_slot_if.latch       slot
);

  logic load_payload;

  // payload only moves on an accepted, valid fetch
  assign load_payload = ~stall_i & fetch_valid_i;

  // flush wins over stall
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot.valid <= 1'b0;
    end else if (flush_i) begin
      slot.valid <= 1'b0;
    end else if (!stall_i) begin
      slot.valid <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (load_payload) begin
      slot.error   <= fetch_error_i;
      slot.addr    <= fetch_addr_i;
      slot.insn    <= fetch_insn_i;
      slot.bptag   <= fetch_bptag_i;
      slot.bptaken <= fetch_bptaken_i;
    end
  end

endmodule

`default_nettype wire

//--- source/decode_slot_if.sv
// latched fetch slot, driven by the pipeline register and read by the decoders and issue logic
`timescale 1ns/10ps
`default_nettype none

interface decode_slot_if import decode_pkg::*; ();

  logic               valid;
  logic               error;
  logic [XLEN-1:1]    addr;
  logic [XLEN-1:0]    insn;
  logic [BPTAG_W-1:0] bptag;
  logic               bptaken;

  modport latch (
    output valid,
    output error,
    output addr,
    output insn,
    output bptag,
    output bptaken
  );

  modport sink (
    input valid,
    input error,
    input addr,
    input insn,
    input bptag,
    input bptaken
  );

endinterface

`default_nettype wire

//--- source/decode_pkg.sv
// shared opcode, format, exception cause and width definitions for the decode stage
`default_nettype none

package decode_pkg;

  localparam int XLEN    = 32;
  localparam int BPTAG_W = 16;
  localparam int ROBID_W = 8;
  localparam int RSOP_W  = 5;
  localparam int RETOP_W = 7;

  // major opcodes, instruction bits 6 to 2
  typedef enum logic [4:0] {
    OPC_LOAD       = 5'b00000,
    OPC_LOAD_FP    = 5'b00001,
    OPC_CUSTOM_0   = 5'b00010,
    OPC_MISC_MEM   = 5'b00011,
    OPC_OP_IMM     = 5'b00100,
    OPC_AUIPC      = 5'b00101,
    OPC_OP_IMM_32  = 5'b00110,
    OPC_48B_0      = 5'b00111,
    OPC_STORE      = 5'b01000,
    OPC_STORE_FP   = 5'b01001,
    OPC_CUSTOM_1   = 5'b01010,
    OPC_AMO        = 5'b01011,
    OPC_OP         = 5'b01100,
    OPC_LUI        = 5'b01101,
    OPC_OP_32      = 5'b01110,
    OPC_64B        = 5'b01111,
    OPC_MADD       = 5'b10000,
    OPC_MSUB       = 5'b10001,
    OPC_NMSUB      = 5'b10010,
    OPC_NMADD      = 5'b10011,
    OPC_OP_FP      = 5'b10100,
    OPC_RESERVED_0 = 5'b10101,
    OPC_CUSTOM_2   = 5'b10110,
    OPC_48B_1      = 5'b10111,
    OPC_BRANCH     = 5'b11000,
    OPC_JALR       = 5'b11001,
    OPC_RESERVED_1 = 5'b11010,
    OPC_JAL        = 5'b11011,
    OPC_SYSTEM     = 5'b11100,
    OPC_RESERVED_2 = 5'b11101,
    OPC_CUSTOM_3   = 5'b11110,
    OPC_80B        = 5'b11111
  } opcode_e;

  // one-hot instruction format
  typedef enum logic [6:0] {
    FMT_R       = 7'b1000000,
    FMT_I       = 7'b0100000,
    FMT_S       = 7'b0010000,
    FMT_B       = 7'b0001000,
    FMT_U       = 7'b0000100,
    FMT_J       = 7'b0000010,
    FMT_INVALID = 7'b0000001
  } fmt_e;

  typedef enum logic [1:0] {
    ECAUSE_IALIGN  = 2'd0,
    ECAUSE_IFAULT  = 2'd1,
    ECAUSE_ILLEGAL = 2'd2
  } ecause_e;

  typedef struct packed {
    fmt_e            fmt;
    logic [XLEN-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            uses_rd;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            uses_imm;
  } field_res_t;

  typedef struct packed {
    logic [RSOP_W-1:0]  rsop;
    logic [RETOP_W-1:0] retop;
    logic               is_load;
    logic               is_jalr;
    logic               is_auipc;
    logic               is_csr;
  } op_res_t;

endpackage

`default_nettype wire
